// ==== files.f ====
verilog/obi_pkg.sv
verilog/thread_pkg.sv
verilog/thread_dispatcher.sv
verilog/thread_engine.sv
verilog/thread_engine_top.sv
test/tb_thread_engine.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the thread engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_thread_engine \
    -Mdir obj_dir \
    -f files.f

out=$(./obj_dir/Vtb_thread_engine)
echo "$out"

# Pass only when the testbench reports success
if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

// ==== test/tb_thread_engine.sv ====
/*
 * Thread engine testbench
 * Directed bus, launch and completion tests against a simple cluster model
 */
`default_nettype none

module tb_thread_engine
    import obi_pkg::*;
    import thread_pkg::*;
();

    // ######################################
    // DUT signals
    // ######################################

    logic        clk = 1'b0;
    logic        rst_n;
    obi_req_t    obi_req;
    obi_rsp_t    obi_rsp;
    logic        flush_ic;
    logic        inorder_exec;
    logic        warp_free = 1'b0;
    logic        alloc_valid;
    warp_alloc_t alloc;
    logic        done_ready;
    logic        done_valid = 1'b0;
    tgroup_id_t  done_id = '0;

    // Result tallies
    int error_cnt   = 0;
    int timeout_cnt = 0;

    // Host side state
    logic [ObiIdWidth-1:0] next_aid = '0;
    launch_cfg_t           exp_cfg;
    logic                  exp_inorder = 1'b0;
    int                    alloc_base  = 0;
    int                    flush_base  = 0;

    // Warp mode 0 holds warps busy, 1 frees them and 2 toggles at random
    int         wf_mode     = 0;
    logic       done_en     = 1'b1;
    int         foreign_req = 0;
    tgroup_id_t foreign_id  = '0;

    // Cluster model state
    warp_alloc_t alloc_log[$];
    int          flush_cnt       = 0;
    int          free_violations = 0;
    int          done_ptr        = 0;
    int          done_gap        = 0;
    int          foreign_sent    = 0;

    initial begin
        forever #4 clk = ~clk;
    end

    thread_engine_top u_dut (
        .clk_i               (clk),
        .rst_n_i             (rst_n),
        .obi_req_i           (obi_req),
        .obi_rsp_o           (obi_rsp),
        .flush_ic_o          (flush_ic),
        .inorder_execution_o (inorder_exec),
        .warp_free_i         (warp_free),
        .allocate_warp_o     (alloc_valid),
        .allocate_o          (alloc),
        .tblock_done_ready_o (done_ready),
        .tblock_done_i       (done_valid),
        .tblock_done_id_i    (done_id)
    );

    // ######################################
    // Cluster model
    // ######################################

    // Log allocations and flushes mid cycle
    always @(negedge clk) begin
        if (rst_n && alloc_valid) begin
            alloc_log.push_back(alloc);
            if (!warp_free) begin
                free_violations++;
            end
        end
        if (rst_n && flush_ic) begin
            flush_cnt++;
        end
    end

    // Warp availability
    always @(posedge clk) begin
        #1;
        case (wf_mode)
            0: warp_free = 1'b0;
            1: warp_free = 1'b1;
            default: warp_free = ($urandom_range(1) != 0);
        endcase
    end

    // Completion reports with foreign ids going first
    always @(posedge clk) begin
        #1;
        done_valid = 1'b0;
        if (done_gap > 0) begin
            done_gap--;
        end else if (rst_n && done_ready) begin
            if (foreign_sent < foreign_req) begin
                done_valid = 1'b1;
                done_id    = foreign_id;
                foreign_sent++;
            end else if (done_en && done_ptr < alloc_log.size()) begin
                // Return the oldest block after a random gap
                done_valid = 1'b1;
                done_id    = alloc_log[done_ptr].tgroup_id;
                done_ptr++;
                done_gap   = $urandom_range(3);
            end
        end
    end

    // ######################################
    // Compare tasks
    // ######################################

    task automatic check_rsp(input obi_r_chan_t got, input obi_r_chan_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s response %h, expected %h", $time, what, got, exp);
            error_cnt++;
        end
    endtask

    task automatic check_alloc(input warp_alloc_t got, input warp_alloc_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: allocation %h, expected %h", $time, got, exp);
            error_cnt++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            error_cnt++;
        end
    endtask

    // Status layout {disp, 12 zero bits, fin count, inorder, finished, running, start}
    function automatic logic [ObiDataWidth-1:0] expected_status(
        input logic start, input logic running, input logic finished,
        input logic inorder, input tblock_idx_t fin, input tblock_idx_t disp);
        return {disp, 12'd0, fin, inorder, finished, running, start};
    endfunction

    // ######################################
    // Bus tasks
    // ######################################

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    // One OBI transfer entered just after a rising edge
    task automatic obi_access(input logic we, input reg_idx_t idx, input logic [31:0] wdata,
                              input logic [3:0] be, output obi_r_chan_t rsp,
                              output logic [ObiIdWidth-1:0] aid);
        int waited;
        aid              = next_aid;
        next_aid         = next_aid + 4'd1;
        obi_req.req      = 1'b1;
        obi_req.a.addr   = {26'd0, idx, 2'b00};
        obi_req.a.we     = we;
        obi_req.a.be     = be;
        obi_req.a.wdata  = wdata;
        obi_req.a.aid    = aid;
        // Grant comes back in the same cycle
        @(negedge clk);
        check_bit(obi_rsp.gnt, 1'b1, "grant");
        @(posedge clk);
        #1;
        obi_req.req = 1'b0;
        // Response due one cycle after the request
        check_bit(obi_rsp.rvalid, 1'b1, "rvalid one cycle after request");
        waited      = 0;
        while (!obi_rsp.rvalid && waited < 8) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!obi_rsp.rvalid) begin
            $display("Timeout: no bus response for an access to register %0d", idx);
            timeout_cnt++;
        end
        rsp = obi_rsp.r;
    endtask

    task automatic obi_write(input reg_idx_t idx, input logic [31:0] wdata,
                             input logic [3:0] be, input string what);
        obi_r_chan_t           rsp;
        obi_r_chan_t           exp;
        logic [ObiIdWidth-1:0] aid;
        obi_access(1'b1, idx, wdata, be, rsp, aid);
        exp.rdata = '0;
        exp.rid   = aid;
        exp.err   = (idx > 4'd5);
        check_rsp(rsp, exp, what);
    endtask

    task automatic obi_read(input reg_idx_t idx, input logic [31:0] exp_data,
                            input string what);
        obi_r_chan_t           rsp;
        obi_r_chan_t           exp;
        logic [ObiIdWidth-1:0] aid;
        obi_access(1'b0, idx, '0, 4'hF, rsp, aid);
        exp.rdata = exp_data;
        exp.rid   = aid;
        exp.err   = (idx > 4'd5);
        check_rsp(rsp, exp, what);
    endtask

    // ######################################
    // Launch tasks
    // ######################################

    // Random launch parameters
    task automatic configure(input int n, input tgroup_id_t gid);
        logic [31:0] rnd;
        rnd                  = $urandom;
        exp_cfg.pc           = rnd[15:0];
        exp_cfg.dp_addr      = $urandom;
        rnd                  = $urandom;
        exp_cfg.tblock_size  = rnd[3:0];
        exp_cfg.num_tblocks  = tblock_idx_t'(n);
        exp_cfg.tgroup_id    = gid;
        obi_write(RegPc, {16'd0, exp_cfg.pc}, 4'hF, "pc write");
        obi_write(RegDpAddr, exp_cfg.dp_addr, 4'hF, "dp_addr write");
        obi_write(RegNumTblocks, {24'd0, exp_cfg.num_tblocks}, 4'hF, "block count write");
        obi_write(RegTgroupId, {24'd0, gid}, 4'hF, "group id write");
        obi_write(RegTblockSize, {28'd0, exp_cfg.tblock_size}, 4'hF, "block size write");
    endtask

    task automatic start_launch(input logic be0, input logic val0);
        alloc_base = alloc_log.size();
        flush_base = flush_cnt;
        obi_write(RegStatus, {31'd0, val0}, {3'b111, be0}, "status write");
        if (be0) begin
            exp_inorder = val0;
        end
    endtask

    task automatic wait_finished();
        obi_r_chan_t           rsp;
        logic [ObiIdWidth-1:0] aid;
        int                    polls;
        polls = 0;
        rsp   = '0;
        while (!rsp.rdata[StatFinished] && polls < 400) begin
            obi_access(1'b0, RegStatus, '0, 4'hF, rsp, aid);
            polls++;
        end
        if (!rsp.rdata[StatFinished]) begin
            $display("Timeout: launch still not finished after %0d status polls", polls);
            timeout_cnt++;
        end
    endtask

    task automatic wait_allocs(input int count);
        int waited;
        waited = 0;
        while (alloc_log.size() < count && waited < 100) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (alloc_log.size() < count) begin
            $display("Timeout: only %0d of %0d allocations seen", alloc_log.size(), count);
            timeout_cnt++;
        end
    endtask

    // Stream, flush and final status of a finished launch
    task automatic check_launch();
        warp_alloc_t exp;
        int          n;
        n = int'(exp_cfg.num_tblocks);
        check_bit(flush_cnt - flush_base == 1, 1'b1, "single flush pulse");
        check_bit(alloc_log.size() - alloc_base == n, 1'b1, "allocation count");
        check_bit(free_violations == 0, 1'b1, "no allocation without a free warp");
        for (int i = 0; i < n && alloc_base + i < alloc_log.size(); i++) begin
            exp.pc          = exp_cfg.pc;
            exp.dp_addr     = exp_cfg.dp_addr;
            exp.tblock_size = exp_cfg.tblock_size;
            exp.tblock_idx  = tblock_idx_t'(i);
            exp.tgroup_id   = exp_cfg.tgroup_id;
            check_alloc(alloc_log[alloc_base + i], exp);
        end
        obi_read(RegStatus, expected_status(1'b0, 1'b0, 1'b1, exp_inorder,
                 exp_cfg.num_tblocks, exp_cfg.num_tblocks), "status after launch");
        check_bit(inorder_exec, exp_inorder, "inorder_execution_o");
        check_bit(done_ready, 1'b0, "tblock_done_ready_o after finish");
    endtask

    task automatic run_launch(input int n, input tgroup_id_t gid, input logic be0,
                              input logic val0);
        configure(n, gid);
        start_launch(be0, val0);
        wait_finished();
        check_launch();
    endtask

    // ######################################
    // Directed tests
    // ######################################

    task automatic reset_and_registers();
        logic [31:0] val;
        logic [31:0] mask;
        check_bit(alloc_valid, 1'b0, "allocate_warp_o after reset");
        check_bit(flush_ic, 1'b0, "flush_ic_o after reset");
        check_bit(done_ready, 1'b0, "tblock_done_ready_o after reset");
        check_bit(obi_rsp.rvalid, 1'b0, "rvalid after reset");
        check_bit(inorder_exec, 1'b0, "inorder_execution_o after reset");
        obi_read(RegStatus, '0, "status after reset");
        // Read-back masked to each field width
        for (int i = 0; i < 5; i++) begin
            val = $urandom;
            case (i)
                0: mask = 32'h0000_FFFF;
                1: mask = 32'hFFFF_FFFF;
                2, 3: mask = 32'h0000_00FF;
                default: mask = 32'h0000_000F;
            endcase
            obi_write(reg_idx_t'(i), val, 4'hF, "config write");
            obi_read(reg_idx_t'(i), val & mask, "config read-back");
        end
        obi_read(4'd6, '0, "unmapped read");
        obi_write(4'd6, 32'h1234_5678, 4'hF, "unmapped write");
    endtask

    task automatic launch_and_allocation();
        wf_mode = 1;
        run_launch(5, 8'h21, 1'b1, 1'b0);
    endtask

    task automatic back_pressure();
        wf_mode = 2;
        run_launch(12, 8'h42, 1'b1, 1'b0);
        wf_mode = 1;
    endtask

    task automatic completion_counting();
        int waited;
        done_en = 1'b0;
        configure(4, 8'h63);
        start_launch(1'b1, 1'b0);
        wait_allocs(alloc_base + 4);
        // Reports for another group while the real ones are held back
        foreign_id  = 8'h63 ^ 8'h5A;
        foreign_req = foreign_req + 3;
        waited      = 0;
        while (foreign_sent < foreign_req && waited < 50) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (foreign_sent < foreign_req) begin
            $display("Timeout: foreign completion reports were never accepted");
            timeout_cnt++;
        end
        idle(2);
        obi_read(RegStatus, expected_status(1'b0, 1'b1, 1'b0, exp_inorder, 8'd0, 8'd4),
                 "status after foreign reports");
        done_en = 1'b1;
        wait_finished();
        check_launch();
    endtask

    task automatic write_protection();
        wf_mode = 0;
        configure(6, 8'h84);
        start_launch(1'b1, 1'b1);
        idle(3);
        check_bit(alloc_log.size() == alloc_base, 1'b1, "no allocation while warps busy");
        // Everything below must be ignored while running
        obi_write(RegPc, ~{16'd0, exp_cfg.pc}, 4'hF, "pc write while running");
        obi_write(RegDpAddr, ~exp_cfg.dp_addr, 4'hF, "dp_addr write while running");
        obi_write(RegNumTblocks, 32'd9, 4'hF, "block count write while running");
        obi_write(RegTgroupId, {24'd0, ~exp_cfg.tgroup_id}, 4'hF, "group write while running");
        obi_write(RegTblockSize, {28'd0, ~exp_cfg.tblock_size}, 4'hF, "size write while running");
        obi_write(RegStatus, 32'd0, 4'hF, "second status write");
        obi_read(RegPc, {16'd0, exp_cfg.pc}, "pc kept");
        obi_read(RegDpAddr, exp_cfg.dp_addr, "dp_addr kept");
        obi_read(RegNumTblocks, {24'd0, exp_cfg.num_tblocks}, "block count kept");
        obi_read(RegTgroupId, {24'd0, exp_cfg.tgroup_id}, "group id kept");
        obi_read(RegTblockSize, {28'd0, exp_cfg.tblock_size}, "block size kept");
        obi_read(RegStatus, expected_status(1'b0, 1'b1, 1'b0, exp_inorder, 8'd0, 8'd0),
                 "status while stalled");
        check_bit(inorder_exec, exp_inorder, "inorder flag while running");
        check_bit(done_ready, 1'b1, "tblock_done_ready_o while running");
        wf_mode = 1;
        wait_finished();
        check_launch();
    endtask

    task automatic inorder_flag();
        run_launch(3, 8'h15, 1'b1, 1'b1);
        // Byte 0 disabled keeps the flag
        run_launch(2, 8'h16, 1'b0, 1'b0);
        run_launch(2, 8'h17, 1'b1, 1'b0);
        flush_base = flush_cnt;
        obi_write(RegNumTblocks, 32'd0, 4'hF, "zero block count");
        obi_write(RegStatus, 32'd1, 4'hF, "status write with zero blocks");
        idle(2);
        obi_read(RegStatus, expected_status(1'b0, 1'b0, 1'b1, exp_inorder, 8'd2, 8'd2),
                 "status after empty launch");
        check_bit(inorder_exec, exp_inorder, "inorder flag after empty launch");
        check_bit(flush_cnt == flush_base, 1'b1, "no flush for empty launch");
    endtask

    // ######################################
    // Main sequence
    // ######################################

    initial begin
        void'($urandom(32'h1785f5b4));
        rst_n   = 1'b0;
        obi_req = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_and_registers();
        launch_and_allocation();
        back_pressure();
        completion_counting();
        write_protection();
        inorder_flag();
        idle(4);
        $display("Errors: %0d, timeouts: %0d", error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/obi_pkg.sv ====
/*
 * OBI bus definitions
 * Widths and the request and response channel structs of the register bus
 */
`default_nettype none

package obi_pkg;

    // Bus widths
    localparam int unsigned ObiAddrWidth = 32;
    localparam int unsigned ObiDataWidth = 32;
    localparam int unsigned ObiIdWidth   = 4;

    // Address phase payload
    typedef struct packed {
        logic [ObiAddrWidth-1:0]   addr;
        logic                      we;
        logic [ObiDataWidth/8-1:0] be;
        logic [ObiDataWidth-1:0]   wdata;
        logic [ObiIdWidth-1:0]     aid;
    } obi_a_chan_t;

    typedef struct packed {
        logic        req;
        obi_a_chan_t a;
    } obi_req_t;

    // Response phase payload
    typedef struct packed {
        logic [ObiDataWidth-1:0] rdata;
        logic [ObiIdWidth-1:0]   rid;
        logic                    err;
    } obi_r_chan_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        obi_r_chan_t r;
    } obi_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/thread_dispatcher.sv ====
/*
 * Thread block dispatcher
 * Walks the blocks of one launch and issues one block per free warp
 */
`default_nettype none

module thread_dispatcher
    import thread_pkg::*;
(
    // Clock and reset
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Launch handshake with the engine
    input  logic        start_i,
    input  launch_cfg_t cfg_i,
    output logic        ready_o,

    // Allocation towards the clusters
    input  logic        warp_free_i,
    output logic        allocate_warp_o,
    output warp_alloc_t allocate_o,

    // Blocks issued so far in this launch
    output tblock_idx_t dispatched_o
);

    // ######################################
    // State
    // ######################################

    // Busy while blocks of a launch remain
    logic        busy_q;

    // Launch as seen at acceptance
    launch_cfg_t launch_q;

    // Index of the next block to issue
    tblock_idx_t idx_q;

    logic        accept;
    logic        issue;
    logic        last_blk;

    // ######################################
    // Handshakes
    // ######################################

    // Only take a new launch when idle
    assign ready_o  = !busy_q;
    assign accept   = start_i && !busy_q;

    // One block per cycle with a free warp
    assign issue    = busy_q && warp_free_i;
    assign last_blk = (idx_q == launch_q.num_tblocks - tblock_idx_t'(1));

    assign allocate_warp_o = issue;

    // Index doubles as the issued count
    assign dispatched_o = idx_q;

    // Allocation payload from the latched launch
    always_comb begin
        allocate_o.pc          = launch_q.pc;
        allocate_o.dp_addr     = launch_q.dp_addr;
        allocate_o.tblock_size = launch_q.tblock_size;
        allocate_o.tblock_idx  = idx_q;
        allocate_o.tgroup_id   = launch_q.tgroup_id;
    end

    // ######################################
    // Sequential logic
    // ######################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (accept) begin
            // Fresh launch starts at block zero
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (issue) begin
            idx_q <= idx_q + tblock_idx_t'(1);
            // Back to idle once the last block is out
            if (last_blk) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Launch copy
    always_ff @(posedge clk_i) begin
        if (accept) begin
            launch_q <= cfg_i;
        end
    end

    // ######################################
    // Assertions
    // ######################################

    // Every block of the launch is out before going idle
    a_all_issued : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $fell(busy_q) |-> (idx_q == launch_q.num_tblocks)
    ) else $error("dispatcher went idle with blocks left");

    // Issued index must stay inside the launch
    a_idx_in_range : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        allocate_warp_o |-> (allocate_o.tblock_idx < launch_q.num_tblocks)
    ) else $error("block index beyond the launch block count");

endmodule

`default_nettype wire

// ==== verilog/thread_engine.sv ====
/*
 * Thread engine
 * OBI register file, launch control and completion counting around the dispatcher
 */
`default_nettype none

module thread_engine
    import obi_pkg::*;
    import thread_pkg::*;
(
    // Clock and reset
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Register bus
    input  obi_req_t    obi_req_i,
    output obi_rsp_t    obi_rsp_o,

    // Cluster control
    output logic        flush_ic_o,
    output logic        inorder_execution_o,

    // Warp allocation
    input  logic        warp_free_i,
    output logic        allocate_warp_o,
    output warp_alloc_t allocate_o,

    // Block completion reports
    output logic        tblock_done_ready_o,
    input  logic        tblock_done_i,
    input  tgroup_id_t  tblock_done_id_i
);

    // ######################################
    // Signals
    // ######################################

    // Launch flags
    logic        start_q,    start_d;
    logic        running_q,  running_d;
    logic        finished_q, finished_d;
    logic        inorder_q,  inorder_d;

    // Completed blocks of the current group
    tblock_idx_t fin_cnt_q, fin_cnt_d;

    // Launch configuration
    launch_cfg_t cfg_q, cfg_d;

    // Registered bus response
    logic        rvalid_q;
    obi_r_chan_t r_q, r_d;

    // Decoded register and assembled status
    reg_idx_t                reg_idx;
    logic [ObiDataWidth-1:0] status_word;

    // Dispatcher side
    logic        disp_ready;
    tblock_idx_t disp_cnt;
    logic        done_hit;

    // ######################################
    // Decode and status
    // ######################################

    assign reg_idx = obi_req_i.a.addr[RegIdxMsb:RegIdxLsb];

    always_comb begin
        status_word                            = '0;
        status_word[StatStart]                 = start_q;
        status_word[StatRunning]               = running_q;
        status_word[StatFinished]              = finished_q;
        status_word[StatInorder]               = inorder_q;
        status_word[StatFinCntMsb:StatFinCntLsb] = fin_cnt_q;
        status_word[StatDispMsb:StatDispLsb]   = disp_cnt;
    end

    // Reports only count while running and after the launch is handed off
    assign tblock_done_ready_o = running_q && !start_q;
    assign done_hit = tblock_done_i && tblock_done_ready_o &&
                      (tblock_done_id_i == cfg_q.tgroup_id);

    // ######################################
    // Register file and launch control
    // ######################################

    always_comb begin
        start_d    = start_q;
        running_d  = running_q;
        finished_d = finished_q;
        inorder_d  = inorder_q;
        fin_cnt_d  = fin_cnt_q;
        cfg_d      = cfg_q;

        // Writes answer with zero data
        r_d     = '0;
        r_d.rid = obi_req_i.a.aid;

        if (obi_req_i.req) begin
            case (reg_idx)
                RegPc: begin
                    if (!obi_req_i.a.we) begin
                        r_d.rdata[PcWidth-1:0] = cfg_q.pc;
                    end else if (!running_q) begin
                        cfg_d.pc = obi_req_i.a.wdata[PcWidth-1:0];
                    end
                end
                RegDpAddr: begin
                    if (!obi_req_i.a.we) begin
                        r_d.rdata[AddrWidth-1:0] = cfg_q.dp_addr;
                    end else if (!running_q) begin
                        cfg_d.dp_addr = obi_req_i.a.wdata[AddrWidth-1:0];
                    end
                end
                RegNumTblocks: begin
                    if (!obi_req_i.a.we) begin
                        r_d.rdata[TblockIdxBits-1:0] = cfg_q.num_tblocks;
                    end else if (!running_q) begin
                        cfg_d.num_tblocks = obi_req_i.a.wdata[TblockIdxBits-1:0];
                    end
                end
                RegTgroupId: begin
                    if (!obi_req_i.a.we) begin
                        r_d.rdata[TgroupIdBits-1:0] = cfg_q.tgroup_id;
                    end else if (!running_q) begin
                        cfg_d.tgroup_id = obi_req_i.a.wdata[TgroupIdBits-1:0];
                    end
                end
                RegTblockSize: begin
                    if (!obi_req_i.a.we) begin
                        r_d.rdata[TblockSizeBits-1:0] = cfg_q.tblock_size;
                    end else if (!running_q) begin
                        cfg_d.tblock_size = obi_req_i.a.wdata[TblockSizeBits-1:0];
                    end
                end
                RegStatus: begin
                    if (!obi_req_i.a.we) begin
                        r_d.rdata = status_word;
                    end else if (!running_q && (cfg_q.num_tblocks != '0)) begin
                        // Status write kicks off a launch
                        start_d    = 1'b1;
                        running_d  = 1'b1;
                        finished_d = 1'b0;
                        fin_cnt_d  = '0;
                        // In-order flag from byte 0
                        if (obi_req_i.a.be[0]) begin
                            inorder_d = obi_req_i.a.wdata[0];
                        end
                    end
                end
                default: begin
                    r_d.err = 1'b1;
                end
            endcase
        end

        // Dispatcher took the launch
        if (start_q && disp_ready) begin
            start_d = 1'b0;
        end

        // Matching completion report
        if (done_hit) begin
            fin_cnt_d = fin_cnt_q + tblock_idx_t'(1);
            if (fin_cnt_d == cfg_q.num_tblocks) begin
                running_d  = 1'b0;
                finished_d = 1'b1;
            end
        end
    end

    // Grant in the same cycle and response one cycle later
    always_comb begin
        obi_rsp_o.gnt    = obi_req_i.req;
        obi_rsp_o.rvalid = rvalid_q;
        obi_rsp_o.r      = r_q;
    end

    // Flush the instruction cache as the launch is handed off
    assign flush_ic_o          = start_q && disp_ready;
    assign inorder_execution_o = inorder_q;

    // ######################################
    // Dispatcher
    // ######################################

    thread_dispatcher u_dispatcher (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .start_i         (start_q),
        .cfg_i           (cfg_q),
        .ready_o         (disp_ready),
        .warp_free_i     (warp_free_i),
        .allocate_warp_o (allocate_warp_o),
        .allocate_o      (allocate_o),
        .dispatched_o    (disp_cnt)
    );

    // ######################################
    // Sequential logic
    // ######################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            start_q    <= 1'b0;
            running_q  <= 1'b0;
            finished_q <= 1'b0;
            inorder_q  <= 1'b0;
            fin_cnt_q  <= '0;
            cfg_q      <= '0;
            rvalid_q   <= 1'b0;
        end else begin
            start_q    <= start_d;
            running_q  <= running_d;
            finished_q <= finished_d;
            inorder_q  <= inorder_d;
            fin_cnt_q  <= fin_cnt_d;
            cfg_q      <= cfg_d;
            rvalid_q   <= obi_req_i.req;
        end
    end

    // Response payload
    always_ff @(posedge clk_i) begin
        r_q <= r_d;
    end

    // ######################################
    // Assertions
    // ######################################

    // Every granted request gets its own response next cycle
    // Error flag set only for indices beyond the status register
    a_rsp_after_req : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        obi_req_i.req |=> obi_rsp_o.rvalid &&
                          (obi_rsp_o.r.rid == $past(obi_req_i.a.aid)) &&
                          (obi_rsp_o.r.err == ($past(reg_idx) > RegStatus))
    ) else $error("missing, mistagged or misdecoded bus response");

    // A pending start always belongs to a running launch
    a_start_in_run : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        start_q |-> running_q
    ) else $error("start pending outside a running launch");

    // Launch is either running or finished
    a_run_fin_excl : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(running_q && finished_q)
    ) else $error("running and finished set together");

endmodule

`default_nettype wire

// ==== verilog/thread_engine_top.sv ====
/*
 * Thread engine top level
 * Bus and cluster boundary around the engine
 */
`default_nettype none

module thread_engine_top
    import obi_pkg::*;
    import thread_pkg::*;
(
    // Clock and reset
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Host register bus
    input  obi_req_t    obi_req_i,
    output obi_rsp_t    obi_rsp_o,

    // Instruction cache flush and ordering mode
    output logic        flush_ic_o,
    output logic        inorder_execution_o,

    // Warp allocation to the cluster array
    input  logic        warp_free_i,
    output logic        allocate_warp_o,
    output warp_alloc_t allocate_o,

    // Completion reports from the cluster array
    output logic        tblock_done_ready_o,
    input  logic        tblock_done_i,
    input  tgroup_id_t  tblock_done_id_i
);

    // ######################################
    // Engine
    // ######################################

    // Cluster array attaches on the allocation and completion ports
    thread_engine u_engine (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),

        .obi_req_i           (obi_req_i),
        .obi_rsp_o           (obi_rsp_o),

        .flush_ic_o          (flush_ic_o),
        .inorder_execution_o (inorder_execution_o),

        .warp_free_i         (warp_free_i),
        .allocate_warp_o     (allocate_warp_o),
        .allocate_o          (allocate_o),

        .tblock_done_ready_o (tblock_done_ready_o),
        .tblock_done_i       (tblock_done_i),
        .tblock_done_id_i    (tblock_done_id_i)
    );

endmodule

`default_nettype wire

// ==== verilog/thread_pkg.sv ====
/*
 * Thread launch definitions
 * Launch widths, register map, status layout and launch structs
 */
`default_nettype none

package thread_pkg;

    // Launch widths
    localparam int unsigned PcWidth        = 16;
    localparam int unsigned AddrWidth      = 32;
    localparam int unsigned TblockIdxBits  = 8;
    localparam int unsigned TblockSizeBits = 4;
    localparam int unsigned TgroupIdBits   = 8;

    typedef logic [PcWidth-1:0]        pc_t;
    typedef logic [AddrWidth-1:0]      addr_t;
    typedef logic [TblockIdxBits-1:0]  tblock_idx_t;
    typedef logic [TblockSizeBits-1:0] tblock_size_t;
    typedef logic [TgroupIdBits-1:0]   tgroup_id_t;

    // ######################################
    // Register map
    // ######################################

    // Word index taken from address bits 5..2
    localparam int unsigned RegIdxLsb = 2;
    localparam int unsigned RegIdxMsb = 5;

    typedef logic [RegIdxMsb-RegIdxLsb:0] reg_idx_t;

    localparam reg_idx_t RegPc         = 4'd0;
    localparam reg_idx_t RegDpAddr     = 4'd1;
    localparam reg_idx_t RegNumTblocks = 4'd2;
    localparam reg_idx_t RegTgroupId   = 4'd3;
    localparam reg_idx_t RegTblockSize = 4'd4;
    localparam reg_idx_t RegStatus     = 4'd5;

    // Status word layout
    localparam int unsigned StatStart     = 0;
    localparam int unsigned StatRunning   = 1;
    localparam int unsigned StatFinished  = 2;
    localparam int unsigned StatInorder   = 3;
    localparam int unsigned StatFinCntLsb = 4;
    localparam int unsigned StatFinCntMsb = 11;
    localparam int unsigned StatDispLsb   = 24;
    localparam int unsigned StatDispMsb   = 31;

    // ######################################
    // Launch structs
    // ######################################

    // Configuration handed to the dispatcher
    typedef struct packed {
        pc_t          pc;
        addr_t        dp_addr;
        tblock_idx_t  num_tblocks;
        tgroup_id_t   tgroup_id;
        tblock_size_t tblock_size;
    } launch_cfg_t;

    // Payload that goes with each warp allocation
    typedef struct packed {
        pc_t          pc;
        addr_t        dp_addr;
        tblock_size_t tblock_size;
        tblock_idx_t  tblock_idx;
        tgroup_id_t   tgroup_id;
    } warp_alloc_t;

endpackage

`default_nettype wire
